// File: source/simd_alu_pkg.sv
/*
 * SIMD ALU shared definitions
 * Datapath widths, operand typedefs, element width codes and opcodes
 */

`default_nettype none

package simd_alu_pkg;

  ////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////

  localparam int unsigned ELEN      = 64;
  localparam int unsigned NUM_BYTES = ELEN / 8;

  typedef logic [ELEN-1:0]      elen_t;
  typedef logic [NUM_BYTES-1:0] strb_t;
  typedef logic [NUM_BYTES-1:0] vxsat_t;
  typedef logic [NUM_BYTES-1:0] flags_t;

  // Element width code
  typedef logic [1:0] vew_t;

  localparam vew_t EW8  = 2'd0;
  localparam vew_t EW16 = 2'd1;
  localparam vew_t EW32 = 2'd2;
  localparam vew_t EW64 = 2'd3;

  ////////////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////////////

  typedef logic [4:0] alu_op_t;

  localparam alu_op_t OP_AND   = 5'd0;
  localparam alu_op_t OP_OR    = 5'd1;
  localparam alu_op_t OP_XOR   = 5'd2;
  // Wrapping arithmetic
  localparam alu_op_t OP_ADD   = 5'd3;
  localparam alu_op_t OP_SUB   = 5'd4;
  localparam alu_op_t OP_RSUB  = 5'd5;
  // Saturating arithmetic
  localparam alu_op_t OP_SADDU = 5'd6;
  localparam alu_op_t OP_SADD  = 5'd7;
  localparam alu_op_t OP_SSUBU = 5'd8;
  localparam alu_op_t OP_SSUB  = 5'd9;
  // Shifts
  localparam alu_op_t OP_SLL   = 5'd10;
  localparam alu_op_t OP_SRL   = 5'd11;
  localparam alu_op_t OP_SRA   = 5'd12;
  localparam alu_op_t OP_MERGE = 5'd13;
  // Min and max
  localparam alu_op_t OP_MIN   = 5'd14;
  localparam alu_op_t OP_MINU  = 5'd15;
  localparam alu_op_t OP_MAX   = 5'd16;
  localparam alu_op_t OP_MAXU  = 5'd17;
  // Mask-producing compares
  localparam alu_op_t OP_MSEQ  = 5'd18;
  localparam alu_op_t OP_MSNE  = 5'd19;
  localparam alu_op_t OP_MSLT  = 5'd20;
  localparam alu_op_t OP_MSLTU = 5'd21;
  localparam alu_op_t OP_MSLE  = 5'd22;
  localparam alu_op_t OP_MSLEU = 5'd23;
  localparam alu_op_t OP_MSGT  = 5'd24;
  localparam alu_op_t OP_MSGTU = 5'd25;

  // Ops that compare their operands as signed values
  function automatic logic is_signed_op(alu_op_t op);
    return op inside {OP_MIN, OP_MAX, OP_MSLT, OP_MSLE, OP_MSGT};
  endfunction

endpackage

`default_nettype wire

// File: source/alu_compare.sv
/*
 * Element compare
 * Less-than and equality flags per element, on the element's lowest byte
 */

`timescale 1ns/1ns
`default_nettype none

module alu_compare (
  input  wire simd_alu_pkg::alu_op_t op_i,
  input  wire simd_alu_pkg::vew_t    vew_i,
  input  wire simd_alu_pkg::elen_t   operand_a_i,
  input  wire simd_alu_pkg::elen_t   operand_b_i,
  output simd_alu_pkg::flags_t       less_o,
  output simd_alu_pkg::flags_t       equal_o
);

  logic                 is_signed;
  simd_alu_pkg::flags_t less_w  [4];
  simd_alu_pkg::flags_t equal_w [4];

  assign is_signed = simd_alu_pkg::is_signed_op(op_i);

  // One flag set per element width, picked by vew_i below
  for (genvar w = 0; w < 4; w++) begin : g_width
    localparam int unsigned EW = 8 << w;
    localparam int unsigned NE = simd_alu_pkg::ELEN / EW;

    always_comb begin : p_cmp
      logic [EW-1:0] a_el;
      logic [EW-1:0] b_el;
      less_w[w]  = '0;
      equal_w[w] = '0;
      for (int e = 0; e < NE; e++) begin
        a_el = operand_a_i[e*EW +: EW];
        b_el = operand_b_i[e*EW +: EW];
        // Extra top bit turns the unsigned case into a signed compare
        less_w[w][e*EW/8]  = $signed({is_signed & b_el[EW-1], b_el}) <
                             $signed({is_signed & a_el[EW-1], a_el});
        equal_w[w][e*EW/8] = (a_el == b_el);
      end
    end
  end

  assign less_o  = less_w[vew_i];
  assign equal_o = equal_w[vew_i];

endmodule

`default_nettype wire

// File: source/alu_addsub.sv
/*
 * Element add and subtract
 * Wrapping and saturating variants, saturation flag spread per byte
 */

`timescale 1ns/1ns
`default_nettype none

module alu_addsub (
  input  wire simd_alu_pkg::alu_op_t op_i,
  input  wire simd_alu_pkg::vew_t    vew_i,
  input  wire simd_alu_pkg::elen_t   operand_a_i,
  input  wire simd_alu_pkg::elen_t   operand_b_i,
  output simd_alu_pkg::elen_t        arith_result_o,
  output simd_alu_pkg::vxsat_t       vxsat_o
);

  simd_alu_pkg::elen_t  res_w [4];
  simd_alu_pkg::vxsat_t sat_w [4];

  for (genvar w = 0; w < 4; w++) begin : g_width
    localparam int unsigned EW = 8 << w;
    localparam int unsigned NB = EW / 8;
    localparam int unsigned NE = simd_alu_pkg::ELEN / EW;
    localparam logic [EW-1:0] SMAX = {1'b0, {(EW-1){1'b1}}};
    localparam logic [EW-1:0] SMIN = {1'b1, {(EW-1){1'b0}}};

    always_comb begin : p_arith
      logic [EW-1:0] a_el;
      logic [EW-1:0] b_el;
      logic [EW:0]   sum;
      logic [EW:0]   diff;
      logic [EW-1:0] r_el;
      logic          sat;
      res_w[w] = '0;
      sat_w[w] = '0;
      for (int e = 0; e < NE; e++) begin
        a_el = operand_a_i[e*EW +: EW];
        b_el = operand_b_i[e*EW +: EW];
        sum  = {1'b0, a_el} + {1'b0, b_el};
        // Subtract is b minus a, top bit is the borrow
        diff = {1'b0, b_el} - {1'b0, a_el};
        sat  = 1'b0;
        case (op_i)
          simd_alu_pkg::OP_ADD:  r_el = sum[EW-1:0];
          simd_alu_pkg::OP_SUB:  r_el = diff[EW-1:0];
          simd_alu_pkg::OP_RSUB: r_el = a_el - b_el;
          simd_alu_pkg::OP_SADDU: begin
            sat  = sum[EW];
            r_el = sat ? '1 : sum[EW-1:0];
          end
          simd_alu_pkg::OP_SADD: begin
            // Same operand signs, result sign flipped
            sat  = (a_el[EW-1] == b_el[EW-1]) && (sum[EW-1] != a_el[EW-1]);
            r_el = sat ? (a_el[EW-1] ? SMIN : SMAX) : sum[EW-1:0];
          end
          simd_alu_pkg::OP_SSUBU: begin
            sat  = diff[EW];
            r_el = sat ? '0 : diff[EW-1:0];
          end
          simd_alu_pkg::OP_SSUB: begin
            sat  = (a_el[EW-1] != b_el[EW-1]) && (diff[EW-1] != b_el[EW-1]);
            r_el = sat ? (b_el[EW-1] ? SMIN : SMAX) : diff[EW-1:0];
          end
          default: r_el = '0;
        endcase
        res_w[w][e*EW +: EW] = r_el;
        sat_w[w][e*NB +: NB] = {NB{sat}};
      end
    end
  end

  assign arith_result_o = res_w[vew_i];
  assign vxsat_o        = sat_w[vew_i];

  ////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////

  // Saturation only ever reported for the saturating ops
  always_comb begin : p_sat_check
    if (!(op_i inside {simd_alu_pkg::OP_SADDU, simd_alu_pkg::OP_SADD,
                       simd_alu_pkg::OP_SSUBU, simd_alu_pkg::OP_SSUB})) begin
      assert (vxsat_o == '0)
        else $error("vxsat set for a non-saturating opcode");
    end
  end

endmodule

`default_nettype wire

// File: source/alu_shift.sv
/*
 * Element shifter
 * Logical left, logical right and arithmetic right shift per element
 */

`timescale 1ns/1ns
`default_nettype none

module alu_shift (
  input  wire simd_alu_pkg::alu_op_t op_i,
  input  wire simd_alu_pkg::vew_t    vew_i,
  input  wire simd_alu_pkg::elen_t   operand_a_i,
  input  wire simd_alu_pkg::elen_t   operand_b_i,
  output simd_alu_pkg::elen_t        shift_result_o
);

  simd_alu_pkg::elen_t res_w [4];

  for (genvar w = 0; w < 4; w++) begin : g_width
    localparam int unsigned EW = 8 << w;
    localparam int unsigned SW = $clog2(EW);
    localparam int unsigned NE = simd_alu_pkg::ELEN / EW;

    always_comb begin : p_shift
      logic [EW-1:0] b_el;
      logic [SW-1:0] sh;
      res_w[w] = '0;
      for (int e = 0; e < NE; e++) begin
        b_el = operand_b_i[e*EW +: EW];
        // Amount bits above log2 of the width are dropped
        sh   = operand_a_i[e*EW +: SW];
        case (op_i)
          simd_alu_pkg::OP_SLL: res_w[w][e*EW +: EW] = b_el << sh;
          simd_alu_pkg::OP_SRL: res_w[w][e*EW +: EW] = b_el >> sh;
          simd_alu_pkg::OP_SRA: res_w[w][e*EW +: EW] = $signed(b_el) >>> sh;
          default:              res_w[w][e*EW +: EW] = '0;
        endcase
      end
    end
  end

  assign shift_result_o = res_w[vew_i];

endmodule

`default_nettype wire

// File: source/alu_result_stage.sv
/*
 * Result stage
 * Bitwise, merge, min/max and compare results, final select by opcode
 * and the single output register with valid
 */

`timescale 1ns/1ns
`default_nettype none

module alu_result_stage (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire logic                  valid_i,
  input  wire simd_alu_pkg::alu_op_t op_i,
  input  wire simd_alu_pkg::vew_t    vew_i,
  input  wire simd_alu_pkg::elen_t   operand_a_i,
  input  wire simd_alu_pkg::elen_t   operand_b_i,
  input  wire simd_alu_pkg::strb_t   mask_i,
  input  wire simd_alu_pkg::flags_t  less_i,
  input  wire simd_alu_pkg::flags_t  equal_i,
  input  wire simd_alu_pkg::elen_t   arith_result_i,
  input  wire simd_alu_pkg::vxsat_t  arith_vxsat_i,
  input  wire simd_alu_pkg::elen_t   shift_result_i,
  output logic                       valid_o,
  output simd_alu_pkg::elen_t        result_o,
  output simd_alu_pkg::vxsat_t       vxsat_o
);

  simd_alu_pkg::elen_t  elem_w [4];
  simd_alu_pkg::elen_t  result_d;
  simd_alu_pkg::vxsat_t vxsat_d;
  logic                 valid_q;
  simd_alu_pkg::elen_t  result_q;
  simd_alu_pkg::vxsat_t vxsat_q;

  ////////////////////////////////////////////////////////////////////
  // Merge, min/max and compare per element
  ////////////////////////////////////////////////////////////////////

  for (genvar w = 0; w < 4; w++) begin : g_width
    localparam int unsigned EW = 8 << w;
    localparam int unsigned NB = EW / 8;
    localparam int unsigned NE = simd_alu_pkg::ELEN / EW;

    always_comb begin : p_elem
      logic [EW-1:0] a_el;
      logic [EW-1:0] b_el;
      logic          lt;
      logic          eq;
      logic          mk;
      logic          flag;
      elem_w[w] = '0;
      for (int e = 0; e < NE; e++) begin
        a_el = operand_a_i[e*EW +: EW];
        b_el = operand_b_i[e*EW +: EW];
        // Flags and mask taken from the lowest byte lane
        lt   = less_i[e*NB];
        eq   = equal_i[e*NB];
        mk   = mask_i[e*NB];
        case (op_i)
          simd_alu_pkg::OP_MSEQ:  flag = eq;
          simd_alu_pkg::OP_MSNE:  flag = !eq;
          simd_alu_pkg::OP_MSLT,
          simd_alu_pkg::OP_MSLTU: flag = lt;
          simd_alu_pkg::OP_MSLE,
          simd_alu_pkg::OP_MSLEU: flag = lt | eq;
          simd_alu_pkg::OP_MSGT,
          simd_alu_pkg::OP_MSGTU: flag = !(lt | eq);
          default:                flag = 1'b0;
        endcase
        case (op_i)
          simd_alu_pkg::OP_MERGE: elem_w[w][e*EW +: EW] = mk ? a_el : b_el;
          simd_alu_pkg::OP_MIN,
          simd_alu_pkg::OP_MINU:  elem_w[w][e*EW +: EW] = lt ? b_el : a_el;
          simd_alu_pkg::OP_MAX,
          simd_alu_pkg::OP_MAXU:  elem_w[w][e*EW +: EW] = lt ? a_el : b_el;
          simd_alu_pkg::OP_MSEQ, simd_alu_pkg::OP_MSNE,
          simd_alu_pkg::OP_MSLT, simd_alu_pkg::OP_MSLTU,
          simd_alu_pkg::OP_MSLE, simd_alu_pkg::OP_MSLEU,
          simd_alu_pkg::OP_MSGT, simd_alu_pkg::OP_MSGTU:
            elem_w[w][e*EW +: EW] = {{(EW-2){1'b0}}, mk, flag};
          default:                elem_w[w][e*EW +: EW] = '0;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Result select and output register
  ////////////////////////////////////////////////////////////////////

  always_comb begin : p_select
    result_d = '0;
    vxsat_d  = '0;
    case (op_i)
      simd_alu_pkg::OP_AND: result_d = operand_a_i & operand_b_i;
      simd_alu_pkg::OP_OR:  result_d = operand_a_i | operand_b_i;
      simd_alu_pkg::OP_XOR: result_d = operand_a_i ^ operand_b_i;
      simd_alu_pkg::OP_ADD, simd_alu_pkg::OP_SUB, simd_alu_pkg::OP_RSUB:
        result_d = arith_result_i;
      simd_alu_pkg::OP_SADDU, simd_alu_pkg::OP_SADD,
      simd_alu_pkg::OP_SSUBU, simd_alu_pkg::OP_SSUB: begin
        result_d = arith_result_i;
        vxsat_d  = arith_vxsat_i;
      end
      simd_alu_pkg::OP_SLL, simd_alu_pkg::OP_SRL, simd_alu_pkg::OP_SRA:
        result_d = shift_result_i;
      default: result_d = elem_w[vew_i];
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q  <= 1'b0;
      result_q <= '0;
      vxsat_q  <= '0;
    end else begin
      valid_q  <= valid_i;
      // Idle cycles show zeros
      result_q <= valid_i ? result_d : '0;
      vxsat_q  <= valid_i ? vxsat_d : '0;
    end
  end

  assign valid_o  = valid_q;
  assign result_o = result_q;
  assign vxsat_o  = vxsat_q;

  // Output valid follows an issued op by exactly one cycle
  a_valid_latency : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(valid_o) |-> $past(valid_i))
    else $error("valid_o rose without valid_i one cycle earlier");

  a_defined_op : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i |-> (op_i <= simd_alu_pkg::OP_MSGTU))
    else $error("undefined opcode issued");

endmodule

`default_nettype wire

// File: source/simd_alu.sv
/*
 * SIMD ALU top level
 * 64-bit lane split into 8/16/32/64-bit elements, one output register
 */

`timescale 1ns/1ns
`default_nettype none

module simd_alu (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 valid_i,
  input  wire simd_alu_pkg::alu_op_t op_i,
  input  wire simd_alu_pkg::vew_t    vew_i,
  input  wire simd_alu_pkg::elen_t   operand_a_i,
  input  wire simd_alu_pkg::elen_t   operand_b_i,
  input  wire simd_alu_pkg::strb_t   mask_i,
  output logic                       valid_o,
  output simd_alu_pkg::elen_t        result_o,
  output simd_alu_pkg::vxsat_t       vxsat_o
);

  simd_alu_pkg::flags_t less;
  simd_alu_pkg::flags_t equal;
  simd_alu_pkg::elen_t  arith_result;
  simd_alu_pkg::vxsat_t arith_vxsat;
  simd_alu_pkg::elen_t  shift_result;

  alu_compare alu_compare_inst (
    .op_i        (op_i),
    .vew_i       (vew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .less_o      (less),
    .equal_o     (equal)
  );

  alu_addsub alu_addsub_inst (
    .op_i           (op_i),
    .vew_i          (vew_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .arith_result_o (arith_result),
    .vxsat_o        (arith_vxsat)
  );

  alu_shift alu_shift_inst (
    .op_i           (op_i),
    .vew_i          (vew_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .shift_result_o (shift_result)
  );

  // Final select and output register
  alu_result_stage alu_result_stage_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .valid_i        (valid_i),
    .op_i           (op_i),
    .vew_i          (vew_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .mask_i         (mask_i),
    .less_i         (less),
    .equal_i        (equal),
    .arith_result_i (arith_result),
    .arith_vxsat_i  (arith_vxsat),
    .shift_result_i (shift_result),
    .valid_o        (valid_o),
    .result_o       (result_o),
    .vxsat_o        (vxsat_o)
  );

endmodule

`default_nettype wire

// File: verif/simd_alu_vectors.svh
/*
 * SIMD ALU directed vectors
 * Columns: op, vew, operand a, operand b, mask, expected result, expected vxsat
 */

`ifndef SIMD_ALU_VECTORS_SVH
`define SIMD_ALU_VECTORS_SVH

typedef struct {
  simd_alu_pkg::alu_op_t op;
  simd_alu_pkg::vew_t    vew;
  simd_alu_pkg::elen_t   a;
  simd_alu_pkg::elen_t   b;
  simd_alu_pkg::strb_t   mask;
  simd_alu_pkg::elen_t   result;
  simd_alu_pkg::vxsat_t  vxsat;
} vector_t;

localparam int NUM_VEC = 33;

vector_t vectors [NUM_VEC] = '{
  // Bitwise, wrapping add, sub and reverse sub
  '{5'd0, 2'd3, 64'hFF00FF00F0F0F0F0, 64'h0F0F0F0FFFFF0000, 8'h00, 64'h0F000F00F0F00000, 8'h00},
  '{5'd1, 2'd0, 64'h123456789ABCDEF0, 64'h0F0F0F0F00000000, 8'h00, 64'h1F3F5F7F9ABCDEF0, 8'h00},
  '{5'd2, 2'd1, 64'hFFFF0000AAAA5555, 64'h0F0F0F0FFFFF0000, 8'h00, 64'hF0F00F0F55555555, 8'h00},
  '{5'd3, 2'd0, 64'hFFFF807F010010FF, 64'h01028001FF0020FF, 8'h00, 64'h00010080000030FE, 8'h00},
  '{5'd3, 2'd1, 64'hFFFF00017FFF8000, 64'h0001FFFF00018000, 8'h00, 64'h0000000080000000, 8'h00},
  '{5'd3, 2'd2, 64'h7FFFFFFFFFFFFFFF, 64'h0000000100000001, 8'h00, 64'h8000000000000000, 8'h00},
  '{5'd3, 2'd3, 64'hFFFFFFFFFFFFFFFF, 64'h0000000000000002, 8'h00, 64'h0000000000000001, 8'h00},
  '{5'd4, 2'd0, 64'h0102030405060708, 64'h001003FF80000710, 8'h00, 64'hFF0E00FB7BFA0008, 8'h00},
  '{5'd4, 2'd2, 64'h0000000100000010, 64'h0000000000000020, 8'h00, 64'hFFFFFFFF00000010, 8'h00},
  '{5'd5, 2'd1, 64'h000000051000FFFF, 64'h0001000320000001, 8'h00, 64'hFFFF0002F000FFFE, 8'h00},
  // Saturating
  '{5'd6, 2'd0, 64'hFF800100F07F10FF, 64'h018001000F80F000, 8'h00, 64'hFFFF0200FFFFFFFF, 8'hC2},
  '{5'd7, 2'd1, 64'h7FFF80000001C000, 64'h0001FFFF0002C000, 8'h00, 64'h7FFF800000038000, 8'hF0},
  '{5'd8, 2'd2, 64'h0000000200000001, 64'h0000000100000005, 8'h00, 64'h0000000000000004, 8'hF0},
  '{5'd9, 2'd0, 64'h01FF03807F2000FF, 64'h807F0500FF1000FE, 8'h00, 64'h807F027F80F000FF, 8'hD0},
  '{5'd9, 2'd3, 64'h0000000000000001, 64'h8000000000000000, 8'h00, 64'h8000000000000000, 8'hFF},
  // Shifts with ignored upper amount bits
  '{5'd10, 2'd0, 64'h09070C00FF021003, 64'h0101FF81010FAA11, 8'h00, 64'h0280F081803CAA88, 8'h00},
  '{5'd11, 2'd1, 64'h00040011000F0020, 64'h8000F000FFFF1234, 8'h00, 64'h0800780000011234, 8'h00},
  '{5'd12, 2'd2, 64'h0000000400000021, 64'h800000007FFFFFFE, 8'h00, 64'hF80000003FFFFFFF, 8'h00},
  '{5'd12, 2'd3, 64'h000000000000007F, 64'h8000000000000000, 8'h00, 64'hFFFFFFFFFFFFFFFF, 8'h00},
  // Merge and min/max
  '{5'd13, 2'd0, 64'h1111111111111111, 64'h2222222222222222, 8'hA5, 64'h1122112222112211, 8'h00},
  '{5'd13, 2'd1, 64'hAAAAAAAAAAAAAAAA, 64'hBBBBBBBBBBBBBBBB, 8'h41, 64'hAAAABBBBBBBBAAAA, 8'h00},
  '{5'd14, 2'd0, 64'h807F01FF0010F005, 64'h7F80FF010020E005, 8'h00, 64'h8080FFFF0010E005, 8'h00},
  '{5'd15, 2'd0, 64'h807F01FF0010F005, 64'h7F80FF010020E005, 8'h00, 64'h7F7F01010010E005, 8'h00},
  '{5'd16, 2'd1, 64'h80007FFF0001FFFF, 64'h7FFF8000FFFF0001, 8'h00, 64'h7FFF7FFF00010001, 8'h00},
  '{5'd17, 2'd1, 64'h80007FFF0001FFFF, 64'h7FFF8000FFFF0001, 8'h00, 64'h80008000FFFFFFFF, 8'h00},
  // Compares
  '{5'd18, 2'd0, 64'h0011223344556677, 64'h0012223044550077, 8'h0F, 64'h0100010003030203, 8'h00},
  '{5'd19, 2'd2, 64'h1234567800000000, 64'h1234567800000001, 8'h10, 64'h0000000200000001, 8'h00},
  '{5'd20, 2'd0, 64'h01807FFF05050080, 64'hFF7F800104060080, 8'h00, 64'h0100010001000000, 8'h00},
  '{5'd21, 2'd0, 64'h01807FFF05050080, 64'hFF7F800104060080, 8'hFF, 64'h0203020303020202, 8'h00},
  '{5'd22, 2'd1, 64'h800000050005FFFF, 64'h7FFF000500040000, 8'h00, 64'h0000000100010000, 8'h00},
  '{5'd23, 2'd1, 64'h800000050005FFFF, 64'h7FFF000500040000, 8'h00, 64'h0001000100010001, 8'h00},
  '{5'd24, 2'd2, 64'h8000000000000001, 64'h0000000000000001, 8'h01, 64'h0000000100000002, 8'h00},
  '{5'd25, 2'd2, 64'h8000000000000001, 64'h0000000000000001, 8'h01, 64'h0000000000000002, 8'h00}
};

`endif

// File: verif/simd_alu_tb.sv
/*
 * SIMD ALU testbench
 * Directed table, then random AND/XOR/byte add, checked one cycle later
 */

`timescale 1ns/1ns
`default_nettype none

module simd_alu_tb;

  `include "simd_alu_vectors.svh"

  localparam int RESET_CYCLES   = 8;
  localparam int NUM_RANDOM     = 200;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_VEC + NUM_RANDOM + 20;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  valid_i;
  simd_alu_pkg::alu_op_t op_i;
  simd_alu_pkg::vew_t    vew_i;
  simd_alu_pkg::elen_t   operand_a_i;
  simd_alu_pkg::elen_t   operand_b_i;
  simd_alu_pkg::strb_t   mask_i;
  logic                  valid_o;
  simd_alu_pkg::elen_t   result_o;
  simd_alu_pkg::vxsat_t  vxsat_o;

  // Expected outputs for the op issued on the previous falling edge
  logic                  exp_valid;
  simd_alu_pkg::elen_t   exp_result;
  simd_alu_pkg::vxsat_t  exp_vxsat;
  int unsigned           cycle_count;

  simd_alu simd_alu_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .vew_i       (vew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .mask_i      (mask_i),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .vxsat_o     (vxsat_o)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("TESTBENCH FAILED");
      $fatal(1, "Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////

  task automatic stop_on_mismatch(string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "Output mismatch");
  endtask

  task automatic check_valid(logic got, logic exp);
    if (got !== exp)
      stop_on_mismatch($sformatf("valid_o got %b expected %b", got, exp));
  endtask

  task automatic check_result(simd_alu_pkg::elen_t got, simd_alu_pkg::elen_t exp);
    if (got !== exp)
      stop_on_mismatch($sformatf("result_o got %h expected %h (op %0d)", got, exp, op_i));
  endtask

  task automatic check_vxsat(simd_alu_pkg::vxsat_t got, simd_alu_pkg::vxsat_t exp);
    if (got !== exp)
      stop_on_mismatch($sformatf("vxsat_o got %h expected %h (op %0d)", got, exp, op_i));
  endtask

  // Check the previous op, then drive the next one
  task automatic issue(logic v, simd_alu_pkg::alu_op_t op, simd_alu_pkg::vew_t ew,
                       simd_alu_pkg::elen_t a, simd_alu_pkg::elen_t b,
                       simd_alu_pkg::strb_t m, simd_alu_pkg::elen_t res,
                       simd_alu_pkg::vxsat_t sat);
    @(negedge clk_i);
    check_valid(valid_o, exp_valid);
    check_result(result_o, exp_result);
    check_vxsat(vxsat_o, exp_vxsat);
    valid_i     = v;
    op_i        = op;
    vew_i       = ew;
    operand_a_i = a;
    operand_b_i = b;
    mask_i      = m;
    exp_valid   = v;
    exp_result  = v ? res : '0;
    exp_vxsat   = v ? sat : '0;
  endtask

  // Byte-wise wrapping add, carries stay inside each byte
  function automatic simd_alu_pkg::elen_t add_bytes(simd_alu_pkg::elen_t a,
                                                     simd_alu_pkg::elen_t b);
    simd_alu_pkg::elen_t r;
    r = '0;
    for (int i = 0; i < 8; i++)
      r[i*8 +: 8] = a[i*8 +: 8] + b[i*8 +: 8];
    return r;
  endfunction

  initial begin
    simd_alu_pkg::elen_t a;
    simd_alu_pkg::elen_t b;
    int unsigned         sel;
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    valid_i     = 1'b0;
    op_i        = '0;
    vew_i       = '0;
    operand_a_i = '0;
    operand_b_i = '0;
    mask_i      = '0;
    exp_valid   = 1'b0;
    exp_result  = '0;
    exp_vxsat   = '0;
    cycle_count = 0;
    void'($urandom(32'h068fc348));

    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_n_i = 1'b1;

    // Idle cycles right after reset show zeros
    issue(1'b0, '0, '0, '0, '0, '0, '0, '0);
    issue(1'b0, '0, '0, '0, '0, '0, '0, '0);

    for (int i = 0; i < NUM_VEC; i++)
      issue(1'b1, vectors[i].op, vectors[i].vew, vectors[i].a, vectors[i].b,
            vectors[i].mask, vectors[i].result, vectors[i].vxsat);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      a   = {$urandom, $urandom};
      b   = {$urandom, $urandom};
      sel = $urandom % 3;
      case (sel)
        0:       issue(1'b1, simd_alu_pkg::OP_AND, simd_alu_pkg::vew_t'($urandom % 4),
                       a, b, '0, a & b, '0);
        1:       issue(1'b1, simd_alu_pkg::OP_XOR, simd_alu_pkg::vew_t'($urandom % 4),
                       a, b, '0, a ^ b, '0);
        default: issue(1'b1, simd_alu_pkg::OP_ADD, simd_alu_pkg::EW8,
                       a, b, '0, add_bytes(a, b), '0);
      endcase
    end

    // Drain the last op
    issue(1'b0, '0, '0, '0, '0, '0, '0, '0);
    issue(1'b0, '0, '0, '0, '0, '0, '0, '0);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: simd_alu.f
+incdir+verif
source/simd_alu_pkg.sv
source/alu_compare.sv
source/alu_addsub.sv
source/alu_shift.sv
source/alu_result_stage.sv
source/simd_alu.sv
verif/simd_alu_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f simd_alu.f \
  --top-module simd_alu_tb \
  -o simd_alu_sim

./obj_dir/simd_alu_sim
